// ==== core_pkg.sv ====
`default_nettype none

package core_pkg;

	parameter int xlen = 32;
	parameter int reg_addr_bits = 4; // RV32E has sixteen registers

	typedef enum logic [2:0] {
		s_fetch,
		s_decode,
		s_execute,
		s_memory,
		s_writeback,
		s_halted
	} ctrl_state_e;

	typedef enum logic [3:0] {
		op_add,
		op_sub,
		op_sll,
		op_slt,
		op_sltu,
		op_xor,
		op_srl,
		op_sra,
		op_or,
		op_and,
		op_pass_b // lui only
	} alu_op_e;

	typedef enum logic [3:0] {
		c_alu_reg,
		c_alu_imm,
		c_lui,
		c_auipc,
		c_jal,
		c_jalr,
		c_branch,
		c_load,
		c_store,
		c_halt,
		c_illegal
	} inst_class_e;

	typedef struct packed {
		inst_class_e inst_class;
		alu_op_e alu_op;
		logic [reg_addr_bits-1:0] rs1;
		logic [reg_addr_bits-1:0] rs2;
		logic [reg_addr_bits-1:0] rd;
		logic [2:0] funct3;
		logic [xlen-1:0] imm;
		logic reg_write; // already false when rd is register zero
	} decoded_t;

	typedef struct packed {
		logic [xlen-1:0] addr;
		logic [xlen-1:0] wdata;
		logic [xlen/8-1:0] wstrb;
		logic write;
	} mem_req_t;

	typedef struct packed {
		logic [xlen-1:0] pc;
		logic [reg_addr_bits-1:0] rd;
		logic [xlen-1:0] value;
		logic reg_write;
	} retire_t;

endpackage

`default_nettype wire

// ==== inst_decoder.sv ====
`default_nettype none

module inst_decoder (
	input  logic [core_pkg::xlen-1:0] inst,
	output core_pkg::decoded_t decoded
);

	typedef enum logic [6:0] {
		opc_op = 7'b0110011,
		opc_op_imm = 7'b0010011,
		opc_lui = 7'b0110111,
		opc_auipc = 7'b0010111,
		opc_jal = 7'b1101111,
		opc_jalr = 7'b1100111,
		opc_branch = 7'b1100011,
		opc_load = 7'b0000011,
		opc_store = 7'b0100011,
		opc_system = 7'b1110011
	} opcode_e;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic alt; // funct7 bit 5 selects sub and sra
	logic [core_pkg::xlen-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;

	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	assign alt = inst[30] && (opcode == opc_op || funct3 == 3'b101);

	assign imm_i = {{20{inst[31]}}, inst[31:20]};
	assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_u = {inst[31:12], 12'b0};
	assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

	always_comb begin
		decoded = '0;
		decoded.rs1 = inst[18:15];
		decoded.rs2 = inst[23:20];
		decoded.rd = inst[10:7];
		decoded.funct3 = funct3;
		decoded.alu_op = core_pkg::op_add; // address and auipc sums
		case (opcode)
			opc_op: decoded.inst_class = core_pkg::c_alu_reg;
			opc_op_imm: decoded.inst_class = core_pkg::c_alu_imm;
			opc_lui: decoded.inst_class = core_pkg::c_lui;
			opc_auipc: decoded.inst_class = core_pkg::c_auipc;
			opc_jal: decoded.inst_class = core_pkg::c_jal;
			opc_jalr: decoded.inst_class = core_pkg::c_jalr;
			opc_branch: decoded.inst_class = (funct3[2:1] == 2'b01) ? core_pkg::c_illegal
			                                                          : core_pkg::c_branch;
			opc_load: decoded.inst_class = (funct3 == 3'b011 || funct3[2:1] == 2'b11)
			                               ? core_pkg::c_illegal : core_pkg::c_load;
			opc_store: decoded.inst_class = (funct3 > 3'b010) ? core_pkg::c_illegal
			                                                   : core_pkg::c_store;
			opc_system: decoded.inst_class = (inst == 32'h0010_0073) ? core_pkg::c_halt
			                                                          : core_pkg::c_illegal;
			default: decoded.inst_class = core_pkg::c_illegal;
		endcase
		case (opcode)
			opc_store: decoded.imm = imm_s;
			opc_branch: decoded.imm = imm_b;
			opc_lui, opc_auipc: decoded.imm = imm_u;
			opc_jal: decoded.imm = imm_j;
			default: decoded.imm = imm_i;
		endcase
		if (opcode == opc_op || opcode == opc_op_imm) begin
			case (funct3)
				3'b000: decoded.alu_op = alt ? core_pkg::op_sub : core_pkg::op_add;
				3'b001: decoded.alu_op = core_pkg::op_sll;
				3'b010: decoded.alu_op = core_pkg::op_slt;
				3'b011: decoded.alu_op = core_pkg::op_sltu;
				3'b100: decoded.alu_op = core_pkg::op_xor;
				3'b101: decoded.alu_op = alt ? core_pkg::op_sra : core_pkg::op_srl;
				3'b110: decoded.alu_op = core_pkg::op_or;
				default: decoded.alu_op = core_pkg::op_and;
			endcase
		end else if (opcode == opc_lui) begin
			decoded.alu_op = core_pkg::op_pass_b;
		end
		case (decoded.inst_class)
			core_pkg::c_alu_reg, core_pkg::c_alu_imm, core_pkg::c_lui, core_pkg::c_auipc,
			core_pkg::c_jal, core_pkg::c_jalr, core_pkg::c_load:
				decoded.reg_write = inst[10:7] != '0;
			default: decoded.reg_write = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

// ==== alu.sv ====
`default_nettype none

module alu (
	input  core_pkg::alu_op_e op,
	input  logic [core_pkg::xlen-1:0] a,
	input  logic [core_pkg::xlen-1:0] b,
	input  logic [2:0] funct3,
	output logic [core_pkg::xlen-1:0] result,
	output logic branch_taken
);

	logic [4:0] shamt;
	logic less_signed;
	logic less_unsigned;
	logic equal;

	assign shamt = b[4:0];
	assign less_signed = $signed(a) < $signed(b);
	assign less_unsigned = a < b;
	assign equal = a == b;

	always_comb begin
		case (op)
			core_pkg::op_add: result = a + b;
			core_pkg::op_sub: result = a - b;
			core_pkg::op_sll: result = a << shamt;
			core_pkg::op_slt: result = {31'b0, less_signed};
			core_pkg::op_sltu: result = {31'b0, less_unsigned};
			core_pkg::op_xor: result = a ^ b;
			core_pkg::op_srl: result = a >> shamt;
			core_pkg::op_sra: result = $signed(a) >>> shamt;
			core_pkg::op_or: result = a | b;
			core_pkg::op_and: result = a & b;
			core_pkg::op_pass_b: result = b;
			default: result = '0;
		endcase
	end

	// only meaningful for branches, where b is rs2
	always_comb begin
		case (funct3)
			3'b000: branch_taken = equal;
			3'b001: branch_taken = !equal;
			3'b100: branch_taken = less_signed;
			3'b101: branch_taken = !less_signed;
			3'b110: branch_taken = less_unsigned;
			3'b111: branch_taken = !less_unsigned;
			default: branch_taken = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

// ==== register_file.sv ====
`default_nettype none

module register_file (
	input  logic clock,
	input  logic reset,
	input  logic [core_pkg::reg_addr_bits-1:0] raddr1,
	input  logic [core_pkg::reg_addr_bits-1:0] raddr2,
	input  logic [core_pkg::reg_addr_bits-1:0] waddr,
	input  logic [core_pkg::xlen-1:0] wdata,
	input  logic wen,
	output logic [core_pkg::xlen-1:0] rdata1,
	output logic [core_pkg::xlen-1:0] rdata2
);

	localparam int depth = 2 ** core_pkg::reg_addr_bits;

	logic [core_pkg::xlen-1:0] regs [depth];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < depth; i++)
				regs[i] <= '0;
		end else if (wen && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

	assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

// ==== load_store_unit.sv ====
`default_nettype none

module load_store_unit (
	input  core_pkg::ctrl_state_e state,
	input  logic [core_pkg::xlen-1:0] pc,
	input  logic [core_pkg::xlen-1:0] addr,
	input  logic [core_pkg::xlen-1:0] store_data,
	input  logic [2:0] funct3,
	input  logic is_store,
	input  logic [core_pkg::xlen-1:0] mem_rdata,
	output core_pkg::mem_req_t req,
	output logic [core_pkg::xlen-1:0] load_value
);

	logic [3:0] lane_strb;
	logic [core_pkg::xlen-1:0] lane_data;
	logic [core_pkg::xlen-1:0] shifted;

	always_comb begin
		case (funct3[1:0])
			2'b00: begin
				lane_data = {4{store_data[7:0]}};
				lane_strb = 4'b0001 << addr[1:0];
			end
			2'b01: begin
				lane_data = {2{store_data[15:0]}};
				lane_strb = 4'b0011 << {addr[1], 1'b0};
			end
			default: begin
				lane_data = store_data;
				lane_strb = 4'b1111;
			end
		endcase
	end

	// the bus address is word aligned, wstrb and the load shift pick the lanes
	always_comb begin
		if (state == core_pkg::s_memory) begin
			req.addr = {addr[31:2], 2'b00};
			req.wdata = lane_data;
			req.wstrb = is_store ? lane_strb : 4'b0000;
			req.write = is_store;
		end else begin
			req = '{addr: {pc[31:2], 2'b00}, wdata: '0, wstrb: 4'b0000, write: 1'b0};
		end
	end

	assign shifted = mem_rdata >> {addr[1:0], 3'b000};

	always_comb begin
		case (funct3)
			3'b000: load_value = {{24{shifted[7]}}, shifted[7:0]};
			3'b100: load_value = {24'b0, shifted[7:0]};
			3'b001: load_value = {{16{shifted[15]}}, shifted[15:0]};
			3'b101: load_value = {16'b0, shifted[15:0]};
			default: load_value = mem_rdata;
		endcase
	end

endmodule

`default_nettype wire

// ==== core_control.sv ====
`default_nettype none

module core_control #(
	parameter logic [core_pkg::xlen-1:0] reset_pc = '0
) (
	input  logic clock,
	input  logic reset,
	input  core_pkg::decoded_t decoded,
	input  logic branch_taken,
	input  logic [core_pkg::xlen-1:0] alu_result,
	input  logic [core_pkg::xlen-1:0] load_value,
	input  logic [core_pkg::xlen-1:0] rdata1,
	input  logic [core_pkg::xlen-1:0] rdata2,
	input  logic mem_ready,
	input  logic [core_pkg::xlen-1:0] mem_rdata,
	output core_pkg::ctrl_state_e state,
	output logic [core_pkg::xlen-1:0] pc,
	output logic [core_pkg::xlen-1:0] inst,
	output logic [core_pkg::xlen-1:0] alu_a,
	output logic [core_pkg::xlen-1:0] alu_b,
	output logic mem_valid,
	output logic reg_write,
	output logic retire_valid,
	output core_pkg::retire_t retire,
	output logic halted
);

	core_pkg::ctrl_state_e next_state;
	logic transfer;
	logic [core_pkg::xlen-1:0] pc_plus4;
	logic [core_pkg::xlen-1:0] branch_target;
	logic [core_pkg::xlen-1:0] target_pc;
	logic [core_pkg::xlen-1:0] next_pc;
	logic [core_pkg::xlen-1:0] load_data;
	logic [core_pkg::xlen-1:0] wb_value;

	assign transfer = mem_valid && mem_ready;
	assign pc_plus4 = pc + 32'd4;
	assign branch_target = pc + decoded.imm; // also the jal target

	always_comb begin
		case (decoded.inst_class)
			core_pkg::c_jal: target_pc = branch_target;
			core_pkg::c_jalr: target_pc = alu_result & ~32'd1;
			core_pkg::c_branch: target_pc = branch_taken ? branch_target : pc_plus4;
			default: target_pc = pc_plus4;
		endcase
	end

	always_comb begin
		next_state = state;
		case (state)
			core_pkg::s_fetch: if (transfer) next_state = core_pkg::s_decode;
			core_pkg::s_decode: next_state = core_pkg::s_execute;
			core_pkg::s_execute: begin
				if (decoded.inst_class == core_pkg::c_load ||
				    decoded.inst_class == core_pkg::c_store)
					next_state = core_pkg::s_memory;
				else
					next_state = core_pkg::s_writeback;
			end
			core_pkg::s_memory: if (transfer) next_state = core_pkg::s_writeback;
			core_pkg::s_writeback: begin
				if (decoded.inst_class == core_pkg::c_halt ||
				    decoded.inst_class == core_pkg::c_illegal)
					next_state = core_pkg::s_halted;
				else
					next_state = core_pkg::s_fetch;
			end
			default: next_state = core_pkg::s_halted;
		endcase
	end

	// valid is registered so the request is held steady from the edge it is raised
	always_ff @(posedge clock) begin
		if (reset) begin
			state <= core_pkg::s_fetch;
			pc <= reset_pc;
			mem_valid <= 1'b0;
		end else begin
			state <= next_state;
			mem_valid <= next_state == core_pkg::s_fetch || next_state == core_pkg::s_memory;
			if (state == core_pkg::s_writeback)
				pc <= next_pc;
		end
	end

	always_ff @(posedge clock) begin
		if (state == core_pkg::s_fetch && transfer)
			inst <= mem_rdata;
		if (state == core_pkg::s_decode) begin
			alu_a <= (decoded.inst_class == core_pkg::c_auipc) ? pc : rdata1;
			alu_b <= (decoded.inst_class == core_pkg::c_alu_reg ||
			          decoded.inst_class == core_pkg::c_branch) ? rdata2 : decoded.imm;
		end
		if (state == core_pkg::s_execute)
			next_pc <= target_pc;
		if (state == core_pkg::s_memory && transfer)
			load_data <= load_value; // load_value only holds during the transfer cycle
	end

	always_comb begin
		case (decoded.inst_class)
			core_pkg::c_jal, core_pkg::c_jalr: wb_value = pc_plus4;
			core_pkg::c_load: wb_value = load_data;
			default: wb_value = alu_result;
		endcase
	end

	assign reg_write = state == core_pkg::s_writeback && decoded.reg_write;
	assign retire_valid = state == core_pkg::s_writeback;
	assign retire = '{pc: pc, rd: decoded.rd, value: wb_value, reg_write: decoded.reg_write};
	assign halted = state == core_pkg::s_halted;

endmodule

`default_nettype wire

// ==== core_top.sv ====
`default_nettype none

module core_top #(
	parameter logic [core_pkg::xlen-1:0] reset_pc = '0
) (
	input  logic clock,
	input  logic reset,
	input  logic mem_ready,
	input  logic [core_pkg::xlen-1:0] mem_rdata,
	output logic mem_valid,
	output core_pkg::mem_req_t mem_req,
	output logic retire_valid,
	output core_pkg::retire_t retire,
	output logic halted
);

	core_pkg::ctrl_state_e state;
	core_pkg::decoded_t decoded;
	logic [core_pkg::xlen-1:0] pc;
	logic [core_pkg::xlen-1:0] inst;
	logic [core_pkg::xlen-1:0] alu_a;
	logic [core_pkg::xlen-1:0] alu_b;
	logic [core_pkg::xlen-1:0] alu_result;
	logic branch_taken;
	logic [core_pkg::xlen-1:0] rdata1;
	logic [core_pkg::xlen-1:0] rdata2;
	logic [core_pkg::xlen-1:0] load_value;
	logic reg_write;

	core_control #(
		.reset_pc(reset_pc)
	) core_control_i (
		.clock(clock),
		.reset(reset),
		.decoded(decoded),
		.branch_taken(branch_taken),
		.alu_result(alu_result),
		.load_value(load_value),
		.rdata1(rdata1),
		.rdata2(rdata2),
		.mem_ready(mem_ready),
		.mem_rdata(mem_rdata),
		.state(state),
		.pc(pc),
		.inst(inst),
		.alu_a(alu_a),
		.alu_b(alu_b),
		.mem_valid(mem_valid),
		.reg_write(reg_write),
		.retire_valid(retire_valid),
		.retire(retire),
		.halted(halted)
	);

	inst_decoder inst_decoder_i (
		.inst(inst),
		.decoded(decoded)
	);

	alu alu_i (
		.op(decoded.alu_op),
		.a(alu_a),
		.b(alu_b),
		.funct3(decoded.funct3),
		.result(alu_result),
		.branch_taken(branch_taken)
	);

	// write-back data and register number come from the retire record
	register_file register_file_i (
		.clock(clock),
		.reset(reset),
		.raddr1(decoded.rs1),
		.raddr2(decoded.rs2),
		.waddr(retire.rd),
		.wdata(retire.value),
		.wen(reg_write),
		.rdata1(rdata1),
		.rdata2(rdata2)
	);

	load_store_unit load_store_unit_i (
		.state(state),
		.pc(pc),
		.addr(alu_result),
		.store_data(rdata2),
		.funct3(decoded.funct3),
		.is_store(decoded.inst_class == core_pkg::c_store),
		.mem_rdata(mem_rdata),
		.req(mem_req),
		.load_value(load_value)
	);

endmodule

`default_nettype wire

// ==== core_tb.sv ====
`default_nettype none

module core_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam logic [31:0] reset_pc = 32'h0000_0000;
	localparam logic [6:0] opc_imm = 7'h13;
	localparam logic [6:0] opc_load = 7'h03;
	localparam logic [6:0] opc_jalr = 7'h67;
	localparam logic [6:0] opc_lui = 7'h37;
	localparam logic [6:0] opc_auipc = 7'h17;

	logic clock;
	logic reset = 1'b1;
	logic mem_ready = 1'b0;
	logic [31:0] mem_rdata = '0;
	logic mem_valid;
	core_pkg::mem_req_t mem_req;
	logic retire_valid;
	core_pkg::retire_t retire;
	logic halted;

	logic [7:0] mem [1024]; // byte addressed and little endian
	string name_q [$];
	core_pkg::retire_t expected_q [$];
	core_pkg::mem_req_t held_req;
	logic busy = 1'b0;
	int wait_left = 0;
	int cycles = 0;
	int cycle_limit = 0;

	core_top #(
		.reset_pc(reset_pc)
	) core_top_i (
		.clock(clock),
		.reset(reset),
		.mem_ready(mem_ready),
		.mem_rdata(mem_rdata),
		.mem_valid(mem_valid),
		.mem_req(mem_req),
		.retire_valid(retire_valid),
		.retire(retire),
		.halted(halted)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	task automatic fail_run(string reason);
		$display("%s", reason);
		$display("*** FAILED ***");
		$fatal(1);
	endtask

	task automatic check_retire(string name, core_pkg::retire_t expected,
	                            core_pkg::retire_t actual);
		logic mismatch;
		mismatch = actual.pc !== expected.pc || actual.reg_write !== expected.reg_write;
		// rd and value only carry meaning when the register is written
		if (expected.reg_write && (actual.rd !== expected.rd || actual.value !== expected.value))
			mismatch = 1'b1;
		if (mismatch)
			fail_run($sformatf("error: %s expected pc %h rd x%0d value %h reg_write %b, %s",
			                   name, expected.pc, expected.rd, expected.value, expected.reg_write,
			                   $sformatf("actual pc %h rd x%0d value %h reg_write %b", actual.pc,
			                             actual.rd, actual.value, actual.reg_write)));
	endtask

	task automatic check_request(string name, core_pkg::mem_req_t expected,
	                             core_pkg::mem_req_t actual);
		if (actual !== expected)
			fail_run($sformatf("error: %s expected addr %h wdata %h wstrb %b write %b, %s",
			                   name, expected.addr, expected.wdata, expected.wstrb, expected.write,
			                   $sformatf("actual addr %h wdata %h wstrb %b write %b", actual.addr,
			                             actual.wdata, actual.wstrb, actual.write)));
	endtask

	task automatic check_halted(string name, logic expected, logic actual);
		if (actual !== expected)
			fail_run($sformatf("error: %s expected halted %b actual %b", name, expected, actual));
	endtask

	task automatic check_level(string name, logic expected, logic actual);
		if (actual !== expected)
			fail_run($sformatf("error: %s expected %b actual %b", name, expected, actual));
	endtask

	function automatic logic [31:0] encode_r(int f7, int rs2, int rs1, int f3, int rd);
		return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
	endfunction

	function automatic logic [31:0] encode_i(int imm, int rs1, int f3, int rd, logic [6:0] opc);
		return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
	endfunction

	function automatic logic [31:0] encode_s(int imm, int rs2, int rs1, int f3);
		return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'h23};
	endfunction

	function automatic logic [31:0] encode_b(int imm, int rs2, int rs1, int f3);
		return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
	endfunction

	function automatic logic [31:0] encode_u(int imm20, int rd, logic [6:0] opc);
		return {imm20[19:0], rd[4:0], opc};
	endfunction

	function automatic logic [31:0] encode_j(int imm, int rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
	endfunction

	task automatic write_word(logic [31:0] addr, logic [31:0] data, logic [3:0] strb);
		logic [9:0] base;
		base = addr[9:0];
		for (int k = 0; k < 4; k++) begin
			if (strb[0])
				mem[base] = data[7:0];
			base = base + 10'd1;
			data = data >> 8;
			strb = strb >> 1;
		end
	endtask

	function automatic logic [31:0] read_word(logic [31:0] addr);
		logic [9:0] base;
		base = addr[9:0];
		return {mem[base + 10'd3], mem[base + 10'd2], mem[base + 10'd1], mem[base]};
	endfunction

	task automatic fill_memory();
		for (int i = 0; i < 1024; i++)
			mem[i[9:0]] = 8'(i * 13) ^ 8'(i >> 8);
	endtask

	// places the instruction at pc and queues the retire record it should produce
	task automatic append_test(string name, logic [31:0] pc, logic [31:0] inst, int rd,
	                           logic [31:0] value, logic wr);
		core_pkg::retire_t entry;
		entry.pc = pc;
		entry.rd = rd[3:0];
		entry.value = value;
		entry.reg_write = wr;
		write_word(pc, inst, 4'b1111);
		name_q.push_back(name);
		expected_q.push_back(entry);
	endtask

	task automatic build_table();
		append_test("addi neg", 32'h00, encode_i(-5, 0, 0, 1, opc_imm), 1, 32'hffff_fffb, 1'b1);
		append_test("addi pos", 32'h04, encode_i(7, 0, 0, 2, opc_imm), 2, 32'h0000_0007, 1'b1);
		append_test("add", 32'h08, encode_r(0, 2, 1, 0, 3), 3, 32'h0000_0002, 1'b1);
		append_test("sub neg", 32'h0c, encode_r(32, 2, 1, 0, 4), 4, 32'hffff_fff4, 1'b1);
		append_test("sub pos", 32'h10, encode_r(32, 1, 2, 0, 5), 5, 32'h0000_000c, 1'b1);
		append_test("slt", 32'h14, encode_r(0, 2, 1, 2, 6), 6, 32'h0000_0001, 1'b1);
		append_test("sltu", 32'h18, encode_r(0, 2, 1, 3, 7), 7, 32'h0000_0000, 1'b1);
		append_test("srai", 32'h1c, encode_i('h401, 1, 5, 8, opc_imm), 8, 32'hffff_fffd, 1'b1);
		append_test("srli", 32'h20, encode_i(1, 1, 5, 9, opc_imm), 9, 32'h7fff_fffd, 1'b1);
		append_test("xor", 32'h24, encode_r(0, 2, 1, 4, 10), 10, 32'hffff_fffc, 1'b1);
		append_test("or", 32'h28, encode_r(0, 2, 1, 6, 11), 11, 32'hffff_ffff, 1'b1);
		append_test("and", 32'h2c, encode_r(0, 2, 1, 7, 12), 12, 32'h0000_0003, 1'b1);
		append_test("lui", 32'h30, encode_u('h12345, 13, opc_lui), 13, 32'h1234_5000, 1'b1);
		append_test("auipc", 32'h34, encode_u(1, 14, opc_auipc), 14, 32'h0000_1034, 1'b1);
		append_test("write x0", 32'h38, encode_i(9, 1, 0, 0, opc_imm), 0, 32'h0, 1'b0);
		append_test("read x0", 32'h3c, encode_r(0, 2, 0, 0, 15), 15, 32'h0000_0007, 1'b1);
		append_test("base", 32'h40, encode_i('h200, 0, 0, 5, opc_imm), 5, 32'h0000_0200, 1'b1);
		append_test("lui data", 32'h44, encode_u('h89abd, 6, opc_lui), 6, 32'h89ab_d000, 1'b1);
		// -529 is -0x211, which takes 0x89abd000 down to 0x89abcdef
		append_test("addi data", 32'h48, encode_i(-529, 6, 0, 6, opc_imm), 6, 32'h89ab_cdef, 1'b1);
		append_test("sw", 32'h4c, encode_s(0, 6, 5, 2), 0, 32'h0, 1'b0);
		append_test("lw", 32'h50, encode_i(0, 5, 2, 7, opc_load), 7, 32'h89ab_cdef, 1'b1);
		append_test("lb", 32'h54, encode_i(0, 5, 0, 8, opc_load), 8, 32'hffff_ffef, 1'b1);
		append_test("lbu", 32'h58, encode_i(1, 5, 4, 9, opc_load), 9, 32'h0000_00cd, 1'b1);
		append_test("lh", 32'h5c, encode_i(2, 5, 1, 10, opc_load), 10, 32'hffff_89ab, 1'b1);
		append_test("lhu", 32'h60, encode_i(0, 5, 5, 11, opc_load), 11, 32'h0000_cdef, 1'b1);
		append_test("sb", 32'h64, encode_s(1, 2, 5, 0), 0, 32'h0, 1'b0);
		append_test("lw after sb", 32'h68, encode_i(0, 5, 2, 12, opc_load), 12, 32'h89ab_07ef, 1'b1);
		append_test("sh", 32'h6c, encode_s(2, 1, 5, 1), 0, 32'h0, 1'b0);
		append_test("lw after sh", 32'h70, encode_i(0, 5, 2, 13, opc_load), 13, 32'hfffb_07ef, 1'b1);
		append_test("lh positive", 32'h74, encode_i(0, 5, 1, 14, opc_load), 14, 32'h0000_07ef, 1'b1);
		append_test("beq taken", 32'h78, encode_b(8, 2, 2, 0), 0, 32'h0, 1'b0);
		append_test("beq not taken", 32'h80, encode_b(8, 2, 1, 0), 0, 32'h0, 1'b0);
		append_test("bne taken", 32'h84, encode_b(8, 2, 1, 1), 0, 32'h0, 1'b0);
		append_test("bne not taken", 32'h8c, encode_b(8, 2, 2, 1), 0, 32'h0, 1'b0);
		append_test("jal", 32'h90, encode_j(12, 1), 1, 32'h0000_0094, 1'b1);
		append_test("jalr base", 32'h9c, encode_i('hb0, 0, 0, 3, opc_imm), 3, 32'h0000_00b0, 1'b1);
		append_test("jalr", 32'ha0, encode_i(4, 3, 0, 4, opc_jalr), 4, 32'h0000_00a4, 1'b1);
		append_test("link sum", 32'hb4, encode_r(0, 4, 1, 0, 15), 15, 32'h0000_0138, 1'b1);
		append_test("ebreak", 32'hb8, 32'h0010_0073, 0, 32'h0, 1'b0);
	endtask

	always @(negedge clock) begin
		if (reset) begin
			mem_ready = 1'b0;
			busy = 1'b0;
		end else begin
			if (mem_ready) begin // the transfer completed at the last rising edge
				if (held_req.write)
					write_word(held_req.addr, held_req.wdata, held_req.wstrb);
				mem_ready = 1'b0;
				busy = 1'b0;
			end
			if (busy && (!mem_valid || mem_req != held_req))
				fail_run("the memory request changed before mem_ready was given");
			if (mem_valid && !busy) begin
				if (mem_req.addr[31:10] != '0)
					fail_run($sformatf("memory access at %h lies outside the 1 KiB model",
					                   mem_req.addr));
				busy = 1'b1;
				held_req = mem_req;
				wait_left = $urandom_range(3, 0);
			end
			if (busy) begin
				if (wait_left == 0) begin
					mem_ready = 1'b1;
					mem_rdata = read_word(held_req.addr);
				end else begin
					wait_left--;
				end
			end
		end
	end

	always @(posedge clock) begin
		if (!reset) begin
			cycles++;
			if (cycles > cycle_limit)
				fail_run($sformatf("timeout: the run did not end within %0d cycles", cycle_limit));
		end
	end

	initial begin
		core_pkg::mem_req_t first_req;
		void'($urandom(65));
		fill_memory();
		build_table();
		cycle_limit = name_q.size() * 20;
		repeat (16) @(posedge clock);
		@(negedge clock);
		check_level("mem_valid after reset", 1'b0, mem_valid);
		check_level("retire_valid after reset", 1'b0, retire_valid);
		check_halted("halted after reset", 1'b0, halted);
		reset = 1'b0;
		@(negedge clock);
		while (!mem_valid)
			@(negedge clock);
		first_req = '{addr: reset_pc, wdata: '0, wstrb: '0, write: 1'b0};
		check_request("first fetch", first_req, mem_req);
		for (int i = 0; i < name_q.size(); i++) begin
			@(negedge clock);
			while (!retire_valid)
				@(negedge clock);
			check_retire(name_q[i], expected_q[i], retire);
		end
		repeat (20) begin // ebreak was the last entry
			@(negedge clock);
			check_halted("halted after ebreak", 1'b1, halted);
			check_level("mem_valid after ebreak", 1'b0, mem_valid);
			check_level("retire_valid after ebreak", 1'b0, retire_valid);
		end
		$display("*** PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim.f ====
core_pkg.sv
inst_decoder.sv
alu.sv
register_file.sv
load_store_unit.sv
core_control.sv
core_top.sv
core_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= core_tb
FILE_LIST ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing -j 0
PASS_TEXT ?= *** PASSED ***

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build core_tb with Verilator, run it and look for the pass message"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILE_LIST BUILD_DIR VFLAGS PASS_TEXT"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)
	./$(BUILD_DIR)/V$(TOP) | awk '{ print } index($$0, "$(PASS_TEXT)") { found = 1 } \
		END { exit !found }'

clean:
	rm -rf $(BUILD_DIR)
